/* compile.f */
hdl/cpu_pkg.sv
hdl/mem_rd_if.sv
hdl/instr_mem.sv
hdl/fetch_unit.sv
hdl/exec_unit.sv
hdl/cpu_on_board.sv
verification/tb_cpu_on_board.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log

set -u
set -o pipefail

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_cpu_on_board -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log \
    && { echo "testbench reported failure"; exit 1; }

grep -q "Simulation finished: PASS" sim.log \
    || { echo "no result line in sim.log"; exit 1; }

echo "simulation passed"
exit 0

/* verification/tb_cpu_on_board.sv */
`timescale 1ns/1ns

module tb_cpu_on_board;

    // start address of every test program
    localparam cpu_pkg::addr_t PC_START = 5'd3;
    // cycles allowed between two LEDG changes
    localparam int LEDG_TIMEOUT = 200;

    logic           clock_1hz;
    logic           KEY0;
    logic           load_en;
    cpu_pkg::addr_t load_addr;
    cpu_pkg::byte_t load_data;
    cpu_pkg::byte_t LEDG;
    logic           LEDR0;

    // program image for the current test
    cpu_pkg::byte_t prog [cpu_pkg::MEM_DEPTH];
    // OUT values predicted by the model
    cpu_pkg::byte_t exp_q [$];

    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    cpu_on_board #(
        .PC_RESET (PC_START)
    ) i_dut (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .LEDG      (LEDG),
        .LEDR0     (LEDR0)
    );

    // 8 ns period
    initial begin
        clock_1hz = 1'b0;
        forever #4 clock_1hz = ~clock_1hz;
    end

    // plain LCG, upper bits are the useful ones
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic cpu_pkg::byte_t encode(cpu_pkg::opcode_t op, cpu_pkg::addr_t arg);
        return {op, arg};
    endfunction

    task automatic check_byte(cpu_pkg::byte_t got, cpu_pkg::byte_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // unused bytes stop the core
    task automatic fill_halt();
        foreach (prog[a]) begin
            prog[a] = encode(cpu_pkg::OP_HALT, 5'd0);
        end
    endtask

    // ISA stepper, collects what OUT would show
    task automatic model_run();
        cpu_pkg::addr_t pc;
        cpu_pkg::addr_t next;
        cpu_pkg::addr_t arg;
        cpu_pkg::byte_t acc;
        cpu_pkg::byte_t ins;
        bit             done;
        exp_q.delete();
        pc   = PC_START;
        acc  = 8'd0;
        done = 1'b0;
        for (int s = 0; s < 400 && !done; s++) begin
            ins  = prog[pc];
            arg  = ins[4:0];
            next = pc + 5'd1;
            case (cpu_pkg::opcode_t'(ins[7:5]))
                cpu_pkg::OP_LDI:  acc = {3'b000, arg};
                cpu_pkg::OP_ADDI: acc = acc + {3'b000, arg};
                cpu_pkg::OP_SUBI: acc = acc - {3'b000, arg};
                cpu_pkg::OP_OUT:  exp_q.push_back(acc);
                cpu_pkg::OP_JMP:  next = arg;
                cpu_pkg::OP_JNZ: begin
                    if (acc != 8'd0) begin
                        next = arg;
                    end
                end
                cpu_pkg::OP_HALT: done = 1'b1;
                default: ;
            endcase
            pc = next;
        end
    endtask

    // write the image while KEY0 is low, then 10 more reset cycles
    task automatic load_and_reset();
        for (int a = 0; a < cpu_pkg::MEM_DEPTH; a++) begin
            @(posedge clock_1hz);
            KEY0      <= 1'b0;
            load_en   <= 1'b1;
            load_addr <= cpu_pkg::addr_t'(a);
            load_data <= prog[a];
        end
        @(posedge clock_1hz);
        load_en <= 1'b0;
        // outputs must sit at zero during reset
        repeat (10) begin
            @(negedge clock_1hz);
            check_byte(LEDG, 8'd0, "LEDG in reset");
            check_bit(LEDR0, 1'b0, "LEDR0 in reset");
        end
        @(posedge clock_1hz);
        KEY0 <= 1'b1;
    endtask

    // sampled on the falling edge, away from the DUT updates
    task automatic wait_ledg_change(input cpu_pkg::byte_t prev, output cpu_pkg::byte_t seen,
                                    output bit ok);
        int n;
        n    = 0;
        ok   = 1'b0;
        seen = prev;
        while (!ok && n < LEDG_TIMEOUT) begin
            @(negedge clock_1hz);
            n++;
            if (LEDG !== prev) begin
                seen = LEDG;
                ok   = 1'b1;
            end
        end
    endtask

    // load, predict, run, then watch LEDG hold while the heartbeat runs
    task automatic run_program(input string name, input int hold_cycles);
        cpu_pkg::byte_t prev;
        cpu_pkg::byte_t seen;
        logic           hb;
        bit             ok;
        int             err0;
        err0 = errors;
        model_run();
        load_and_reset();
        prev = 8'd0;
        ok   = 1'b1;
        for (int i = 0; i < exp_q.size() && ok; i++) begin
            wait_ledg_change(prev, seen, ok);
            if (!ok) begin
                errors++;
                $display("timeout: LEDG did not change within %0d cycles in test %s, output %0d",
                         LEDG_TIMEOUT, name, i);
            end else begin
                check_byte(seen, exp_q[i], $sformatf("%s output %0d", name, i));
                prev = seen;
            end
        end
        if (ok) begin
            @(negedge clock_1hz);
            hb = LEDR0;
            repeat (hold_cycles) begin
                @(negedge clock_1hz);
                check_byte(LEDG, prev, {name, " LEDG after last output"});
                check_bit(LEDR0, ~hb, {name, " heartbeat"});
                hb = LEDR0;
            end
        end
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
            $display("test %-20s FAILED with %0d errors", name, errors - err0);
        end else begin
            $display("test %-20s passed, %0d outputs", name, exp_q.size());
        end
    endtask

    task automatic test_heartbeat();
        fill_halt();
        run_program("reset and heartbeat", 20);
    endtask

    task automatic test_start_addr();
        fill_halt();
        // would show 29 if fetch started at 0
        prog[0] = encode(cpu_pkg::OP_LDI, 5'd29);
        prog[1] = encode(cpu_pkg::OP_OUT, 5'd0);
        prog[2] = encode(cpu_pkg::OP_OUT, 5'd0);
        prog[3] = encode(cpu_pkg::OP_LDI, 5'd17);
        prog[4] = encode(cpu_pkg::OP_OUT, 5'd0);
        run_program("start address", 20);
    endtask

    task automatic test_arith();
        fill_halt();
        prog[3]  = encode(cpu_pkg::OP_LDI, 5'd5);
        // below zero to 251
        prog[5]  = encode(cpu_pkg::OP_SUBI, 5'd10);
        // past 255 to 2
        prog[7]  = encode(cpu_pkg::OP_ADDI, 5'd7);
        prog[9]  = encode(cpu_pkg::OP_SUBI, 5'd3);
        prog[11] = encode(cpu_pkg::OP_ADDI, 5'd31);
        prog[13] = encode(cpu_pkg::OP_SUBI, 5'd31);
        prog[15] = encode(cpu_pkg::OP_ADDI, 5'd1);
        for (int a = 4; a <= 16; a += 2) begin
            prog[a] = encode(cpu_pkg::OP_OUT, 5'd0);
        end
        run_program("arithmetic wrap", 20);
    endtask

    task automatic test_jumps();
        fill_halt();
        // countdown 5..1
        prog[3]  = encode(cpu_pkg::OP_LDI, 5'd5);
        prog[4]  = encode(cpu_pkg::OP_OUT, 5'd0);
        prog[5]  = encode(cpu_pkg::OP_SUBI, 5'd1);
        prog[6]  = encode(cpu_pkg::OP_JNZ, 5'd4);
        prog[7]  = encode(cpu_pkg::OP_LDI, 5'd20);
        prog[8]  = encode(cpu_pkg::OP_JMP, 5'd11);
        // in flight behind the JMP, must be flushed
        prog[9]  = encode(cpu_pkg::OP_LDI, 5'd31);
        prog[10] = encode(cpu_pkg::OP_OUT, 5'd0);
        prog[11] = encode(cpu_pkg::OP_ADDI, 5'd2);
        prog[12] = encode(cpu_pkg::OP_OUT, 5'd0);
        run_program("jumps and flush", 20);
    endtask

    task automatic test_halt();
        fill_halt();
        prog[3] = encode(cpu_pkg::OP_LDI, 5'd9);
        prog[4] = encode(cpu_pkg::OP_OUT, 5'd0);
        prog[5] = encode(cpu_pkg::OP_HALT, 5'd0);
        // stuck in the response slot behind HALT
        prog[6] = encode(cpu_pkg::OP_ADDI, 5'd3);
        prog[7] = encode(cpu_pkg::OP_OUT, 5'd0);
        run_program("halt back-pressure", 50);
    endtask

    // operand pairs from the LCG, each value differs from the one before
    task automatic test_random(input string name);
        logic [31:0]      r;
        int               kind;
        int               base;
        cpu_pkg::addr_t   arg;
        cpu_pkg::byte_t   run_acc;
        cpu_pkg::opcode_t op;
        fill_halt();
        run_acc = 8'd0;
        for (int k = 0; k < 13; k++) begin
            r    = lcg_next();
            kind = int'(r[27:16]) % 3;
            r    = lcg_next();
            arg  = r[20:16];
            // nonzero keeps ADDI and SUBI from repeating a value
            if (arg == 5'd0) begin
                arg = 5'd1;
            end
            if (kind == 0) begin
                op = cpu_pkg::OP_LDI;
                if ({3'b000, arg} == run_acc) begin
                    arg = (arg == 5'd31) ? 5'd1 : arg + 5'd1;
                end
                run_acc = {3'b000, arg};
            end else if (kind == 1) begin
                op      = cpu_pkg::OP_ADDI;
                run_acc = run_acc + {3'b000, arg};
            end else begin
                op      = cpu_pkg::OP_SUBI;
                run_acc = run_acc - {3'b000, arg};
            end
            base           = int'(PC_START) + 2 * k;
            prog[base]     = encode(op, arg);
            prog[base + 1] = encode(cpu_pkg::OP_OUT, 5'd0);
        end
        run_program(name, 20);
    endtask

    initial begin
        KEY0         = 1'b0;
        load_en      = 1'b0;
        load_addr    = 5'd0;
        load_data    = 8'd0;
        lcg_state    = 32'd36453;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_heartbeat();
        test_start_addr();
        test_arith();
        test_jumps();
        test_halt();
        test_random("random 1");
        test_random("random 2");
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/cpu_on_board.sv */
`timescale 1ns/1ns

module cpu_on_board #(
    parameter cpu_pkg::addr_t PC_RESET = 5'd3
) (
    input  logic            clock_1hz,
    input  logic            KEY0,
    input  logic            load_en,
    input  cpu_pkg::addr_t  load_addr,
    input  cpu_pkg::byte_t  load_data,
    output cpu_pkg::byte_t  LEDG,
    output logic            LEDR0
);

    // fetch to execute
    logic           instr_valid;
    cpu_pkg::byte_t instr;
    logic           instr_ready;
    // execute back to fetch
    logic           redirect;
    cpu_pkg::addr_t redirect_pc;

    // instruction read channel
    mem_rd_if rd_bus ();

    instr_mem i_mem (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .bus       (rd_bus.memory)
    );

    fetch_unit #(
        .PC_RESET (PC_RESET)
    ) i_fetch (
        .clock_1hz   (clock_1hz),
        .KEY0        (KEY0),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_ready (instr_ready),
        .bus         (rd_bus.fetch),
        .instr_valid (instr_valid),
        .instr       (instr)
    );

    exec_unit i_exec (
        .clock_1hz   (clock_1hz),
        .KEY0        (KEY0),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .LEDG        (LEDG),
        .LEDR0       (LEDR0)
    );

endmodule

/* hdl/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit (
    input  logic            clock_1hz,
    input  logic            KEY0,
    input  logic            instr_valid,
    input  cpu_pkg::byte_t  instr,
    output logic            instr_ready,
    output logic            redirect,
    output cpu_pkg::addr_t  redirect_pc,
    output cpu_pkg::byte_t  LEDG,
    output logic            LEDR0
);

    cpu_pkg::opcode_t op;
    cpu_pkg::addr_t   operand;
    cpu_pkg::byte_t   imm;
    cpu_pkg::byte_t   acc;
    logic             halted;
    logic             accept;

    // decode fields
    assign op      = cpu_pkg::op_of(instr);
    assign operand = cpu_pkg::operand_of(instr);
    // zero-extended immediate
    assign imm     = cpu_pkg::byte_t'(operand);

    // halt stalls the pipe until reset
    assign instr_ready = !halted;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            acc      <= '0;
            LEDG     <= '0;
            LEDR0    <= 1'b0;
            halted   <= 1'b0;
            redirect <= 1'b0;
        end else begin
            // heartbeat, runs even when halted
            LEDR0    <= ~LEDR0;
            // redirect is a one-cycle pulse
            redirect <= 1'b0;
            if (accept) begin
                case (op)
                    cpu_pkg::OP_NOP: begin
                        acc <= acc;
                    end
                    cpu_pkg::OP_LDI: begin
                        acc <= imm;
                    end
                    cpu_pkg::OP_ADDI: begin
                        // mod 256
                        acc <= acc + imm;
                    end
                    cpu_pkg::OP_SUBI: begin
                        acc <= acc - imm;
                    end
                    cpu_pkg::OP_OUT: begin
                        LEDG <= acc;
                    end
                    cpu_pkg::OP_JMP: begin
                        redirect <= 1'b1;
                    end
                    cpu_pkg::OP_JNZ: begin
                        // test acc before any change
                        redirect <= (acc != '0);
                    end
                    cpu_pkg::OP_HALT: begin
                        halted <= 1'b1;
                    end
                    default: begin
                        acc <= acc;
                    end
                endcase
            end
        end
    end

    // jump target, only looked at while redirect is high
    always_ff @(posedge clock_1hz) begin
        if (accept) begin
            redirect_pc <= operand;
        end
    end

    // once halted the program flow is frozen
    property p_no_jump_halted;
        @(posedge clock_1hz) disable iff (!KEY0)
        halted |=> !redirect;
    endproperty

    a_no_jump_halted: assert property (p_no_jump_halted)
        else $error("redirect raised while halted");

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit #(
    parameter cpu_pkg::addr_t PC_RESET = 5'd3
) (
    input  logic            clock_1hz,
    input  logic            KEY0,
    input  logic            redirect,
    input  cpu_pkg::addr_t  redirect_pc,
    input  logic            instr_ready,
    mem_rd_if.fetch         bus,
    output logic            instr_valid,
    output cpu_pkg::byte_t  instr
);

    // next address to request
    cpu_pkg::addr_t pc;
    // one old-path response still to be dropped
    logic           stale;
    logic           ar_fire;
    logic           r_fire;
    logic           resp_ok;

    assign ar_fire = bus.arvalid && bus.arready;
    assign r_fire  = bus.rvalid && bus.rready;
    assign resp_ok = (bus.rresp == cpu_pkg::RESP_OKAY);

    // address always comes straight from the counter
    assign bus.araddr = pc;

    // response slot is the instruction register
    assign instr = bus.rdata;

    // hide old-path data during the redirect cycle and the stale one after it
    assign instr_valid = bus.rvalid && resp_ok && !stale && !redirect;

    // flushed data is taken here and all other data waits on execute
    assign bus.rready = stale || redirect || instr_ready;

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            pc          <= PC_RESET;
            bus.arvalid <= 1'b0;
            stale       <= 1'b0;
        end else begin
            if (redirect) begin
                // restart at the jump target
                pc    <= redirect_pc;
                // old-path read taken at this edge comes back next cycle
                stale <= ar_fire;
                // hold off the new path until that response is gone
                bus.arvalid <= !ar_fire;
            end else begin
                if (ar_fire) begin
                    // wraps 31 -> 0
                    pc <= pc + cpu_pkg::addr_t'(1);
                end
                if (stale && r_fire) begin
                    stale <= 1'b0;
                end
                // keep requesting unless a stale response is still pending
                bus.arvalid <= !stale || r_fire;
            end
        end
    end

    // new path must not start before the flush completes
    property p_no_issue_stale;
        @(posedge clock_1hz) disable iff (!KEY0)
        stale |-> !bus.arvalid;
    endproperty

    a_no_issue_stale: assert property (p_no_issue_stale)
        else $error("read issued while stale response pending");

endmodule

/* hdl/instr_mem.sv */
`timescale 1ns/1ns

module instr_mem (
    input  logic            clock_1hz,
    input  logic            KEY0,
    input  logic            load_en,
    input  cpu_pkg::addr_t  load_addr,
    input  cpu_pkg::byte_t  load_data,
    mem_rd_if.memory        bus
);

    // unified program and data bytes
    cpu_pkg::byte_t mem [cpu_pkg::MEM_DEPTH];

    logic ar_fire;
    logic r_fire;

    // handshakes on both channels
    assign ar_fire = bus.arvalid && bus.arready;
    assign r_fire  = bus.rvalid && bus.rready;

    // take a new address when the slot is empty or drains this cycle
    assign bus.arready = !bus.rvalid || bus.rready;

    // no error cases in this memory
    assign bus.rresp = cpu_pkg::RESP_OKAY;

    // program load, only while the core is held in reset
    always_ff @(posedge clock_1hz) begin
        if (!KEY0 && load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // response slot valid flag
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            bus.rvalid <= 1'b0;
        end else begin
            if (ar_fire) begin
                // new read fills the slot
                bus.rvalid <= 1'b1;
            end else if (r_fire) begin
                bus.rvalid <= 1'b0;
            end
        end
    end

    // read data, one cycle after the address is taken
    always_ff @(posedge clock_1hz) begin
        if (ar_fire) begin
            bus.rdata <= mem[bus.araddr];
        end
    end

    // a stalled response must not move
    property p_resp_hold;
        @(posedge clock_1hz) disable iff (!KEY0)
        (bus.rvalid && !bus.rready) |=> (bus.rvalid && $stable(bus.rdata));
    endproperty

    a_resp_hold: assert property (p_resp_hold)
        else $error("read response changed while stalled");

endmodule

/* hdl/mem_rd_if.sv */
`timescale 1ns/1ns

interface mem_rd_if;

    // read address channel
    logic                arvalid;
    logic                arready;
    cpu_pkg::addr_t      araddr;

    // read data channel
    logic                rvalid;
    logic                rready;
    cpu_pkg::byte_t      rdata;
    logic [1:0]          rresp;

    // fetch side is the master
    modport fetch (
        output arvalid,
        output araddr,
        output rready,
        input  arready,
        input  rvalid,
        input  rdata,
        input  rresp
    );

    // memory side answers
    modport memory (
        input  arvalid,
        input  araddr,
        input  rready,
        output arready,
        output rvalid,
        output rdata,
        output rresp
    );

endinterface

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // address and operand width, fixed by the ISA
    localparam int ADDR_W = 5;
    // instruction, byte and accumulator width
    localparam int DATA_W = 8;
    // opcode field width, upper bits of the instruction
    localparam int OP_W = DATA_W - ADDR_W;
    // unified program and data memory
    localparam int MEM_DEPTH = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] byte_t;

    // AXI read response for a normal access
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // opcode sits in instr[7:5]
    typedef enum logic [OP_W-1:0] {
        OP_NOP  = 3'd0,
        OP_LDI  = 3'd1,
        OP_ADDI = 3'd2,
        OP_SUBI = 3'd3,
        OP_OUT  = 3'd4,
        OP_JMP  = 3'd5,
        OP_JNZ  = 3'd6,
        OP_HALT = 3'd7
    } opcode_t;

    // opcode field of an instruction byte
    function automatic opcode_t op_of(byte_t ins);
        return opcode_t'(ins[DATA_W-1 -: OP_W]);
    endfunction

    // operand field, also used as a jump target
    function automatic addr_t operand_of(byte_t ins);
        return ins[ADDR_W-1:0];
    endfunction

endpackage
